//--- build.f
+incdir+dv
source/htu_pkg.sv
source/htu_ctrl.sv
source/htu_set_entry.sv
source/htu_set_mux.sv
source/bank_htu_top.sv
dv/tb_bank_htu.sv

//--- dv/htu_model.svh
`ifndef HTU_MODEL_SVH
`define HTU_MODEL_SVH

// expected response to one request
typedef struct packed {
  logic        hit;
  logic        kickoff;
  logic        allow_in;
  logic        isu_valid;
  logic        ar_valid;
  logic        need_linefill;
  logic [1:0]  isu_opcode;
  logic [2:0]  way;
  logic [1:0]  off0_state;
  logic [1:0]  off1_state;
  logic [6:0]  set_way_ofs;
  logic [26:0] ar_addr;
} expect_t;

logic [htu_pkg::TAG_W-1:0] mdl_tag [htu_pkg::NUM_SETS][htu_pkg::NUM_WAYS];
logic                      mdl_valid [htu_pkg::NUM_SETS][htu_pkg::NUM_WAYS];
logic [1:0]                mdl_state [htu_pkg::NUM_SETS][htu_pkg::NUM_WAYS][2];
int                        mdl_victim [htu_pkg::NUM_SETS];

function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

function automatic void reset_model();
  for (int s = 0; s < htu_pkg::NUM_SETS; s++) begin
    mdl_victim[s] = 0;
    for (int w = 0; w < htu_pkg::NUM_WAYS; w++) begin
      mdl_valid[s][w]    = 1'b0;
      mdl_state[s][w][0] = htu_pkg::ST_EMPTY;
      mdl_state[s][w][1] = htu_pkg::ST_EMPTY;
    end
  end
endfunction

function automatic expect_t predict(input logic valid, input logic [1:0] op,
                                    input logic [31:4] addr, input logic isu_rdy,
                                    input logic ar_rdy);
  expect_t    e;
  int         s;
  int         v;
  logic [1:0] cur;
  logic       refill;
  logic       clear;
  s = int'(addr[7:5]);
  v = mdl_victim[s];
  e = '0;
  e.way = 3'(v);
  for (int w = 0; w < htu_pkg::NUM_WAYS; w++) begin
    if (mdl_valid[s][w] && mdl_tag[s][w] == addr[31:10]) begin
      e.hit = 1'b1;
      e.way = 3'(w);
    end
  end
  e.off0_state = mdl_state[s][e.way][0];
  e.off1_state = mdl_state[s][e.way][1];
  cur = addr[4] ? e.off1_state : e.off0_state;
  // a read needs a fill on a miss or on an empty half
  refill = (op == htu_pkg::OP_READ) && (!e.hit || cur == htu_pkg::ST_EMPTY);
  clear  = !refill || ar_rdy;
  e.need_linefill = refill;
  e.allow_in      = isu_rdy && clear;
  e.isu_valid     = valid && clear;
  e.ar_valid      = valid && refill && isu_rdy;
  e.kickoff       = valid && e.allow_in;
  e.isu_opcode[0] = (op == htu_pkg::OP_WRITE);
  e.isu_opcode[1] = !e.hit && mdl_valid[s][v] &&
                    (mdl_state[s][v][0] == htu_pkg::ST_DIRTY ||
                     mdl_state[s][v][1] == htu_pkg::ST_DIRTY);
  e.set_way_ofs = {addr[7:5], e.way, addr[4]};
  e.ar_addr     = addr[31:5];
  return e;
endfunction

function automatic void update_model(input expect_t e, input logic [1:0] op,
                                     input logic [31:4] addr, input logic fill,
                                     input logic [5:0] fill_sw);
  int   s;
  int   fs;
  int   fw;
  logic wr;
  logic touch;
  logic rewrite;
  s  = int'(addr[7:5]);
  fs = int'(fill_sw[5:3]);
  fw = int'(fill_sw[2:0]);
  wr = (op == htu_pkg::OP_WRITE);
  // flush and invalidate leave the arrays alone
  touch   = e.kickoff && (op == htu_pkg::OP_READ || wr);
  rewrite = touch && (!e.hit || wr) && fs == s && fw == int'(e.way);
  if (fill && !rewrite) begin
    for (int h = 0; h < 2; h++) begin
      if (mdl_state[fs][fw][h] == htu_pkg::ST_EMPTY) begin
        mdl_state[fs][fw][h] = htu_pkg::ST_CLEAN;
      end
    end
  end
  if (touch && e.hit && wr) begin
    mdl_state[s][e.way][addr[4]] = htu_pkg::ST_DIRTY;
  end else if (touch && !e.hit) begin
    mdl_valid[s][e.way]    = 1'b1;
    mdl_tag[s][e.way]      = addr[31:10];
    mdl_state[s][e.way][0] = htu_pkg::ST_EMPTY;
    mdl_state[s][e.way][1] = htu_pkg::ST_EMPTY;
    if (wr) begin
      mdl_state[s][e.way][addr[4]] = htu_pkg::ST_DIRTY;
    end
    mdl_victim[s] = (mdl_victim[s] + 1) % htu_pkg::NUM_WAYS;
  end
endfunction

`endif

//--- dv/tb_bank_htu.sv
module tb_bank_htu;

  // reset plus the directed requests, with margin
  localparam int DIRECTED_CYCLES = 40;
  localparam int RANDOM_CYCLES   = 400;
  localparam int TIMEOUT_CYCLES  = DIRECTED_CYCLES + RANDOM_CYCLES + 50;

  logic        clk, rst;
  logic        xbar_valid, isu_allow_in, ar_ready, fill_valid;
  logic [1:0]  xbar_ch_id, xbar_opcode;
  logic [31:4] xbar_addr;
  logic [7:0]  xbar_wbuf_id;
  logic [5:0]  fill_set_way;
  logic        allow_in, need_linefill, isu_valid, ar_valid;
  logic [2:0]  linefill_set, linefill_way;
  logic [1:0]  isu_ch_id, isu_opcode, off0_state, off1_state;
  logic [6:0]  set_way_offset;
  logic [7:0]  isu_wbuf_id;
  logic [5:0]  biu_set_way;
  logic [26:0] ar_addr;
  int          errors, checks, cycles;
  logic [31:0] rng;

  `include "htu_model.svh"

  expect_t exp_out;

  bank_htu_top #(
    .NUM_SETS (htu_pkg::NUM_SETS),
    .NUM_WAYS (htu_pkg::NUM_WAYS)
  ) dut (
    .clk_i                             (clk),
    .rst_i                             (rst),
    .xbar_bank_htu_valid_i             (xbar_valid),
    .xbar_bank_htu_allowIn_o           (allow_in),
    .xbar_bank_htu_ch_id_i             (xbar_ch_id),
    .xbar_bank_htu_opcode_i            (xbar_opcode),
    .xbar_bank_htu_addr_i              (xbar_addr),
    .xbar_bank_htu_wbuffer_id_i        (xbar_wbuf_id),
    .htu_isu_need_linefill_o           (need_linefill),
    .htu_isu_linefill_set_o            (linefill_set),
    .htu_isu_linefill_way_o            (linefill_way),
    .htu_isu_valid_o                   (isu_valid),
    .htu_isu_allowIn_i                 (isu_allow_in),
    .htu_isu_ch_id_o                   (isu_ch_id),
    .htu_isu_opcode_o                  (isu_opcode),
    .htu_isu_set_way_offset_o          (set_way_offset),
    .htu_isu_wbuffer_id_o              (isu_wbuf_id),
    .htu_isu_cacheline_offset0_state_o (off0_state),
    .htu_isu_cacheline_offset1_state_o (off1_state),
    .isu_htu_already_done_valid_i      (fill_valid),
    .isu_htu_set_way_i                 (fill_set_way),
    .htu_biu_set_way_o                 (biu_set_way),
    .htu_biu_arvalid_o                 (ar_valid),
    .htu_biu_arready_i                 (ar_ready),
    .htu_biu_araddr_o                  (ar_addr)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("[FAIL] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  //--------------------------------------------------------------------------
  // compare against the model before every edge
  //--------------------------------------------------------------------------
  always @(negedge clk) begin
    if (rst) begin
      reset_model();
    end else begin
      exp_out = predict(xbar_valid, xbar_opcode, xbar_addr, isu_allow_in, ar_ready);
      check_field("xbar_bank_htu_allowIn_o", 32'(allow_in), 32'(exp_out.allow_in));
      check_field("htu_isu_need_linefill_o", 32'(need_linefill), 32'(exp_out.need_linefill));
      check_field("htu_isu_linefill_set_o", 32'(linefill_set), 32'(xbar_addr[7:5]));
      check_field("htu_isu_linefill_way_o", 32'(linefill_way), 32'(exp_out.way));
      check_field("htu_isu_valid_o", 32'(isu_valid), 32'(exp_out.isu_valid));
      check_field("htu_isu_ch_id_o", 32'(isu_ch_id), 32'(xbar_ch_id));
      check_field("htu_isu_opcode_o", 32'(isu_opcode), 32'(exp_out.isu_opcode));
      check_field("htu_isu_set_way_offset_o", 32'(set_way_offset), 32'(exp_out.set_way_ofs));
      check_field("htu_isu_wbuffer_id_o", 32'(isu_wbuf_id), 32'(xbar_wbuf_id));
      check_field("htu_isu_cacheline_offset0_state_o", 32'(off0_state),
                  32'(exp_out.off0_state));
      check_field("htu_isu_cacheline_offset1_state_o", 32'(off1_state),
                  32'(exp_out.off1_state));
      check_field("htu_biu_set_way_o", 32'(biu_set_way), 32'(exp_out.set_way_ofs[6:1]));
      check_field("htu_biu_arvalid_o", 32'(ar_valid), 32'(exp_out.ar_valid));
      check_field("htu_biu_araddr_o", 32'(ar_addr), 32'(exp_out.ar_addr));
      update_model(exp_out, xbar_opcode, xbar_addr, fill_valid, fill_set_way);
    end
  end

  function automatic logic [31:4] make_addr(input logic [21:0] tag, input int set,
                                            input logic ofs);
    return {tag, 2'b00, 3'(set), ofs};
  endfunction

  task automatic drive_cycle(input logic valid, input logic [1:0] op, input logic [31:4] addr,
                             input logic isu_rdy, input logic ar_rdy, input logic fill,
                             input logic [5:0] fill_sw, input logic [9:0] ids);
    @(posedge clk);
    #1;
    xbar_valid   = valid;
    xbar_opcode  = op;
    xbar_addr    = addr;
    {xbar_ch_id, xbar_wbuf_id} = ids;
    isu_allow_in = isu_rdy;
    ar_ready     = ar_rdy;
    fill_valid   = fill;
    fill_set_way = fill_sw;
  endtask

  // one request, held until its outputs have settled
  task automatic request(input logic [1:0] op, input logic [31:4] addr,
                         input logic isu_rdy, input logic ar_rdy);
    drive_cycle(1'b1, op, addr, isu_rdy, ar_rdy, 1'b0, 6'd0, 10'h2a5);
    @(negedge clk);
  endtask

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    errors       = 0;
    checks       = 0;
    cycles       = 0;
    rng          = 32'd76;
    xbar_valid   = 1'b0;
    xbar_opcode  = 2'b00;
    xbar_addr    = '0;
    xbar_ch_id   = '0;
    xbar_wbuf_id = '0;
    isu_allow_in = 1'b1;
    ar_ready     = 1'b1;
    fill_valid   = 1'b0;
    fill_set_way = '0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    // cold read miss goes to way 0 and asks for a fill
    request(htu_pkg::OP_READ, make_addr(22'h0a1, 2, 1'b0), 1'b1, 1'b1);
    check_field("htu_isu_need_linefill_o", 32'(need_linefill), 32'd1);
    check_field("htu_isu_linefill_way_o", 32'(linefill_way), 32'd0);
    check_field("htu_isu_cacheline_offset0_state_o", 32'(off0_state), 32'd0);
    check_field("htu_isu_cacheline_offset1_state_o", 32'(off1_state), 32'd0);
    check_field("htu_biu_arvalid_o", 32'(ar_valid), 32'd1);

    // fill done on set 2 way 0, then the same read hits clean
    drive_cycle(1'b0, htu_pkg::OP_READ, '0, 1'b1, 1'b1, 1'b1, 6'o20, 10'h0);
    request(htu_pkg::OP_READ, make_addr(22'h0a1, 2, 1'b0), 1'b1, 1'b1);
    check_field("htu_isu_need_linefill_o", 32'(need_linefill), 32'd0);
    check_field("htu_isu_cacheline_offset0_state_o", 32'(off0_state), 32'd1);
    check_field("htu_isu_cacheline_offset1_state_o", 32'(off1_state), 32'd1);

    request(htu_pkg::OP_WRITE, make_addr(22'h0a1, 2, 1'b1), 1'b1, 1'b1);
    request(htu_pkg::OP_READ, make_addr(22'h0a1, 2, 1'b1), 1'b1, 1'b1);
    check_field("htu_isu_cacheline_offset1_state_o", 32'(off1_state), 32'd3);

    // write miss takes the next victim without a fill
    request(htu_pkg::OP_WRITE, make_addr(22'h0b2, 2, 1'b0), 1'b1, 1'b1);
    check_field("htu_isu_need_linefill_o", 32'(need_linefill), 32'd0);
    check_field("htu_isu_linefill_way_o", 32'(linefill_way), 32'd1);
    request(htu_pkg::OP_READ, make_addr(22'h0b2, 2, 1'b1), 1'b1, 1'b1);
    check_field("htu_isu_need_linefill_o", 32'(need_linefill), 32'd1);
    check_field("htu_isu_cacheline_offset0_state_o", 32'(off0_state), 32'd3);
    check_field("htu_isu_cacheline_offset1_state_o", 32'(off1_state), 32'd0);

    // set 5 gets a dirty way 0, set 6 stays clean, then both roll over
    for (int i = 0; i < htu_pkg::NUM_WAYS; i++) begin
      request(i == 0 ? htu_pkg::OP_WRITE : htu_pkg::OP_READ,
              make_addr(22'h100 + 22'(i), 5, 1'b0), 1'b1, 1'b1);
      request(htu_pkg::OP_READ, make_addr(22'h100 + 22'(i), 6, 1'b0), 1'b1, 1'b1);
    end
    request(htu_pkg::OP_READ, make_addr(22'h1ff, 5, 1'b0), 1'b1, 1'b1);
    check_field("htu_isu_linefill_way_o", 32'(linefill_way), 32'd0);
    check_field("htu_isu_opcode_o", 32'(isu_opcode), 32'd2);
    request(htu_pkg::OP_READ, make_addr(22'h1ff, 6, 1'b0), 1'b1, 1'b1);
    check_field("htu_isu_linefill_way_o", 32'(linefill_way), 32'd0);
    check_field("htu_isu_opcode_o", 32'(isu_opcode), 32'd0);

    // stalls from the issue stage and from the address channel
    request(htu_pkg::OP_READ, make_addr(22'h0d4, 3, 1'b0), 1'b0, 1'b1);
    check_field("xbar_bank_htu_allowIn_o", 32'(allow_in), 32'd0);
    check_field("htu_biu_arvalid_o", 32'(ar_valid), 32'd0);
    request(htu_pkg::OP_READ, make_addr(22'h0d4, 3, 1'b0), 1'b1, 1'b0);
    check_field("xbar_bank_htu_allowIn_o", 32'(allow_in), 32'd0);
    check_field("htu_isu_valid_o", 32'(isu_valid), 32'd0);
    check_field("htu_biu_arvalid_o", 32'(ar_valid), 32'd1);
    request(htu_pkg::OP_WRITE, make_addr(22'h0e5, 3, 1'b0), 1'b1, 1'b1);
    check_field("htu_isu_linefill_way_o", 32'(linefill_way), 32'd0);

    // random mix over a pool of 16 tags
    for (int n = 0; n < RANDOM_CYCLES; n++) begin
      rng = xorshift32(rng);
      drive_cycle(rng[1:0] != 2'b00, rng[3:2],
                  make_addr({18'h0c3, rng[7:4]}, int'(rng[10:8]), rng[11]),
                  rng[13:12] != 2'b00, rng[15:14] != 2'b00, rng[17:16] == 2'b00,
                  rng[23:18], rng[31:22]);
    end
    drive_cycle(1'b0, htu_pkg::OP_READ, '0, 1'b1, 1'b1, 1'b0, 6'd0, 10'h0);
    @(negedge clk);
    // let the last compare finish
    @(posedge clk);

    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- run.sh
#!/usr/bin/env bash
# compile and run the hit-test stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f build.f --top-module tb_bank_htu -Mdir obj_dir -o tb_bank_htu

out="$(./obj_dir/tb_bank_htu)"
echo "$out"

if grep -qx "Test completed successfully" <<< "$out"; then
  exit 0
else
  exit 1
fi

//--- source/bank_htu_top.sv
module bank_htu_top #(
  parameter int NUM_SETS = htu_pkg::NUM_SETS,
  parameter int NUM_WAYS = htu_pkg::NUM_WAYS
) (
  input  logic                              clk_i,
  input  logic                              rst_i,
  // crossbar request
  input  logic                              xbar_bank_htu_valid_i,
  output logic                              xbar_bank_htu_allowIn_o,
  input  logic [htu_pkg::CH_ID_W-1:0]       xbar_bank_htu_ch_id_i,
  input  logic [1:0]                        xbar_bank_htu_opcode_i,
  input  logic [31:4]                       xbar_bank_htu_addr_i,
  input  logic [htu_pkg::WBUF_ID_W-1:0]     xbar_bank_htu_wbuffer_id_i,
  // issue stage
  output logic                              htu_isu_need_linefill_o,
  output logic [htu_pkg::SET_W-1:0]         htu_isu_linefill_set_o,
  output logic [htu_pkg::WAY_W-1:0]         htu_isu_linefill_way_o,
  output logic                              htu_isu_valid_o,
  input  logic                              htu_isu_allowIn_i,
  output logic [htu_pkg::CH_ID_W-1:0]       htu_isu_ch_id_o,
  output logic [1:0]                        htu_isu_opcode_o,
  output logic [htu_pkg::SET_WAY_OFS_W-1:0] htu_isu_set_way_offset_o,
  output logic [htu_pkg::WBUF_ID_W-1:0]     htu_isu_wbuffer_id_o,
  output logic [1:0]                        htu_isu_cacheline_offset0_state_o,
  output logic [1:0]                        htu_isu_cacheline_offset1_state_o,
  // fill completion
  input  logic                              isu_htu_already_done_valid_i,
  input  logic [htu_pkg::SET_WAY_W-1:0]     isu_htu_set_way_i,
  // read-address channel
  output logic [htu_pkg::SET_WAY_W-1:0]     htu_biu_set_way_o,
  output logic                              htu_biu_arvalid_o,
  input  logic                              htu_biu_arready_i,
  output logic [htu_pkg::LINE_ADDR_W-1:0]   htu_biu_araddr_o
);

  htu_pkg::opcode_e             opcode;
  logic [htu_pkg::SET_W-1:0]    index;
  logic                         offset;
  logic [htu_pkg::TAG_W-1:0]    tag;
  logic [NUM_SETS-1:0]          index_dcd;
  logic [NUM_SETS-1:0]          set_update;
  logic [NUM_SETS-1:0]          set_fill;
  logic [NUM_SETS-1:0]          hit_arr;
  logic [htu_pkg::WAY_W-1:0]    way_arr [NUM_SETS];
  htu_pkg::half_pair_t          state_arr [NUM_SETS];
  logic                         evict_arr [NUM_SETS];
  logic [htu_pkg::WAY_W-1:0]    access_way;
  htu_pkg::half_pair_t          access_pair;
  htu_pkg::half_state_e         access_state;
  logic                         hit;
  logic                         need_evict;
  logic                         kickoff;
  logic                         is_write;
  logic                         state_we;

  //--------------------------------------------------------------------------
  // address split and set decode
  //--------------------------------------------------------------------------
  assign opcode = htu_pkg::opcode_e'(xbar_bank_htu_opcode_i);
  assign index  = xbar_bank_htu_addr_i[7:5];
  assign offset = xbar_bank_htu_addr_i[4];
  assign tag    = xbar_bank_htu_addr_i[31:10];

  // flush and invalidate pass through without touching the arrays
  assign state_we = kickoff &&
                    (opcode != htu_pkg::OP_FLUSH) && (opcode != htu_pkg::OP_INVAL);

  //--------------------------------------------------------------------------
  // set array
  //--------------------------------------------------------------------------
  for (genvar s = 0; s < NUM_SETS; s++) begin : g_set
    localparam logic [htu_pkg::SET_W-1:0] SET_ID = s;

    assign index_dcd[s]  = (index == SET_ID);
    assign set_update[s] = index_dcd[s] && state_we;
    assign set_fill[s]   = isu_htu_already_done_valid_i &&
                           (isu_htu_set_way_i[htu_pkg::SET_WAY_W-1:htu_pkg::WAY_W] == SET_ID);

    htu_set_entry #(
      .NUM_WAYS (NUM_WAYS)
    ) u_set_entry (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .update_i      (set_update[s]),
      .is_write_i    (is_write),
      .tag_i         (tag),
      .offset_i      (offset),
      .fill_i        (set_fill[s]),
      .fill_way_i    (isu_htu_set_way_i[htu_pkg::WAY_W-1:0]),
      .hit_o         (hit_arr[s]),
      .access_way_o  (way_arr[s]),
      .half_states_o (state_arr[s]),
      .need_evict_o  (evict_arr[s])
    );
  end

  // only the indexed set may report a hit
  assign hit = |(hit_arr & index_dcd);

  htu_set_mux #(
    .NUM_SETS  (NUM_SETS),
    .payload_t (logic [htu_pkg::WAY_W-1:0])
  ) u_way_mux (
    .sel_i  (index),
    .data_i (way_arr),
    .data_o (access_way)
  );

  htu_set_mux #(
    .NUM_SETS  (NUM_SETS),
    .payload_t (htu_pkg::half_pair_t)
  ) u_state_mux (
    .sel_i  (index),
    .data_i (state_arr),
    .data_o (access_pair)
  );

  htu_set_mux #(
    .NUM_SETS  (NUM_SETS),
    .payload_t (logic)
  ) u_evict_mux (
    .sel_i  (index),
    .data_i (evict_arr),
    .data_o (need_evict)
  );

  assign access_state = access_pair[offset];

  htu_ctrl u_ctrl (
    .valid_i         (xbar_bank_htu_valid_i),
    .opcode_i        (opcode),
    .hit_i           (hit),
    .access_state_i  (access_state),
    .need_evict_i    (need_evict),
    .isu_allow_in_i  (htu_isu_allowIn_i),
    .ar_ready_i      (htu_biu_arready_i),
    .allow_in_o      (xbar_bank_htu_allowIn_o),
    .kickoff_o       (kickoff),
    .isu_valid_o     (htu_isu_valid_o),
    .isu_opcode_o    (htu_isu_opcode_o),
    .need_linefill_o (htu_isu_need_linefill_o),
    .ar_valid_o      (htu_biu_arvalid_o),
    .is_write_o      (is_write)
  );

  //--------------------------------------------------------------------------
  // outputs to issue stage and bus interface
  //--------------------------------------------------------------------------
  assign htu_isu_linefill_set_o   = index;
  assign htu_isu_linefill_way_o   = access_way;
  assign htu_isu_set_way_offset_o = {index, access_way, offset};
  assign htu_isu_ch_id_o          = xbar_bank_htu_ch_id_i;
  assign htu_isu_wbuffer_id_o     = xbar_bank_htu_wbuffer_id_i;

  assign htu_isu_cacheline_offset0_state_o = access_pair[0];
  assign htu_isu_cacheline_offset1_state_o = access_pair[1];

  assign htu_biu_set_way_o = {index, access_way};
  assign htu_biu_araddr_o  = xbar_bank_htu_addr_i[31:5];

endmodule

//--- source/htu_ctrl.sv
module htu_ctrl (
  input  logic                  valid_i,
  input  htu_pkg::opcode_e      opcode_i,
  input  logic                  hit_i,
  input  htu_pkg::half_state_e  access_state_i,
  input  logic                  need_evict_i,
  input  logic                  isu_allow_in_i,
  input  logic                  ar_ready_i,
  output logic                  allow_in_o,
  output logic                  kickoff_o,
  output logic                  isu_valid_o,
  output logic [1:0]            isu_opcode_o,
  output logic                  need_linefill_o,
  output logic                  ar_valid_o,
  output logic                  is_write_o
);

  logic is_read;
  logic half_empty;
  logic need_refill;
  logic ar_clear;

  //--------------------------------------------------------------------------
  // opcode decode
  //--------------------------------------------------------------------------
  // flush and invalidate only look up, they never refill
  assign is_read    = (opcode_i == htu_pkg::OP_READ);
  assign is_write_o = (opcode_i == htu_pkg::OP_WRITE);

  // refill on a miss, or on a hit whose accessed half holds no data
  assign half_empty  = (access_state_i == htu_pkg::ST_EMPTY);
  assign need_refill = is_read && (!hit_i || half_empty);

  // the read-address channel must take the refill in the same cycle
  assign ar_clear = !need_refill || ar_ready_i;

  //--------------------------------------------------------------------------
  // handshake strobes
  //--------------------------------------------------------------------------
  assign allow_in_o  = isu_allow_in_i && ar_clear;
  assign isu_valid_o = valid_i && ar_clear;
  assign kickoff_o   = valid_i && allow_in_o;

  // issue the read address only once the issue stage can also accept
  assign ar_valid_o = valid_i && need_refill && isu_allow_in_i;

  assign need_linefill_o = need_refill;

  // bit 1 flags a dirty victim, bit 0 flags a write
  assign isu_opcode_o = {need_evict_i, is_write_o};

endmodule

//--- source/htu_pkg.sv
package htu_pkg;

  //--------------------------------------------------------------------------
  // cache bank geometry
  //--------------------------------------------------------------------------
  localparam int NUM_SETS = 8;
  localparam int NUM_WAYS = 8;

  localparam int SET_W = 3;
  localparam int WAY_W = 3;
  localparam int SET_WAY_W = SET_W + WAY_W;
  localparam int SET_WAY_OFS_W = SET_WAY_W + 1;

  // tag is addr[31:10], line address is addr[31:5]
  localparam int TAG_W = 22;
  localparam int LINE_ADDR_W = 27;

  localparam int CH_ID_W = 2;
  localparam int WBUF_ID_W = 8;

  //--------------------------------------------------------------------------
  // encodings
  //--------------------------------------------------------------------------
  // crossbar opcode
  typedef enum logic [1:0] {
    OP_READ  = 2'b00,
    OP_WRITE = 2'b01,
    OP_FLUSH = 2'b10,
    OP_INVAL = 2'b11
  } opcode_e;

  // state of one half line
  typedef enum logic [1:0] {
    ST_EMPTY = 2'b00,
    ST_CLEAN = 2'b01,
    ST_DIRTY = 2'b11
  } half_state_e;

  // index 1 is offset 1, index 0 is offset 0
  typedef half_state_e [1:0] half_pair_t;

endpackage

//--- source/htu_set_entry.sv
module htu_set_entry #(
  parameter int NUM_WAYS = htu_pkg::NUM_WAYS
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      update_i,
  input  logic                      is_write_i,
  input  logic [htu_pkg::TAG_W-1:0] tag_i,
  input  logic                      offset_i,
  input  logic                      fill_i,
  input  logic [htu_pkg::WAY_W-1:0] fill_way_i,
  output logic                      hit_o,
  output logic [htu_pkg::WAY_W-1:0] access_way_o,
  output htu_pkg::half_pair_t       half_states_o,
  output logic                      need_evict_o
);

  typedef logic [htu_pkg::WAY_W-1:0] way_t;

  logic [htu_pkg::TAG_W-1:0] tag_q [NUM_WAYS];
  logic [NUM_WAYS-1:0]       valid_q;
  htu_pkg::half_pair_t       state_q [NUM_WAYS];
  way_t                      victim_q;

  logic [NUM_WAYS-1:0] match;
  way_t                hit_way;
  logic                victim_dirty;
  logic                way_changes;
  logic                fill_blocked;
  htu_pkg::half_pair_t alloc_state;

  //--------------------------------------------------------------------------
  // lookup
  //--------------------------------------------------------------------------
  always_comb begin
    hit_way = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      match[w] = valid_q[w] && (tag_q[w] == tag_i);
      if (match[w]) begin
        hit_way = way_t'(w);
      end
    end
  end

  assign hit_o        = |match;
  assign access_way_o = hit_o ? hit_way : victim_q;

  // on a miss this shows the victim's halves
  assign half_states_o = state_q[access_way_o];

  assign victim_dirty = (state_q[victim_q][0] == htu_pkg::ST_DIRTY) ||
                        (state_q[victim_q][1] == htu_pkg::ST_DIRTY);

  assign need_evict_o = !hit_o && valid_q[victim_q] && victim_dirty;

  //--------------------------------------------------------------------------
  // update
  //--------------------------------------------------------------------------
  // a read hit leaves the way alone, so a fill to it still lands
  assign way_changes  = update_i && (!hit_o || is_write_i);
  assign fill_blocked = way_changes && (access_way_o == fill_way_i);

  // new line: written half dirty, the rest waits for a fill
  always_comb begin
    alloc_state = '{default: htu_pkg::ST_EMPTY};
    if (is_write_i) begin
      alloc_state[offset_i] = htu_pkg::ST_DIRTY;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q  <= '0;
      victim_q <= '0;
      for (int w = 0; w < NUM_WAYS; w++) begin
        state_q[w] <= '{default: htu_pkg::ST_EMPTY};
      end
    end else begin
      // linefill done, empty halves now hold clean data
      if (fill_i && !fill_blocked) begin
        for (int h = 0; h < 2; h++) begin
          if (state_q[fill_way_i][h] == htu_pkg::ST_EMPTY) begin
            state_q[fill_way_i][h] <= htu_pkg::ST_CLEAN;
          end
        end
      end

      if (update_i) begin
        if (hit_o) begin
          if (is_write_i) begin
            state_q[hit_way][offset_i] <= htu_pkg::ST_DIRTY;
          end
        end else begin
          valid_q[victim_q] <= 1'b1;
          state_q[victim_q] <= alloc_state;
          // round robin over the ways
          if (victim_q == way_t'(NUM_WAYS - 1)) begin
            victim_q <= '0;
          end else begin
            victim_q <= victim_q + 1'b1;
          end
        end
      end
    end
  end

  // tag storage
  always_ff @(posedge clk_i) begin
    if (update_i && !hit_o) begin
      tag_q[victim_q] <= tag_i;
    end
  end

endmodule

//--- source/htu_set_mux.sv
module htu_set_mux #(
  parameter int  NUM_SETS  = htu_pkg::NUM_SETS,
  parameter type payload_t = logic
) (
  input  logic [htu_pkg::SET_W-1:0] sel_i,
  input  payload_t                  data_i [NUM_SETS],
  output payload_t                  data_o
);

  // set 0 is the fallback for an index past NUM_SETS
  always_comb begin
    data_o = data_i[0];
    for (int s = 1; s < NUM_SETS; s++) begin
      if (int'(sel_i) == s) begin
        data_o = data_i[s];
      end
    end
  end

endmodule
